// ==== testbench/bus_golden.txt ====
// a_count a_addr b_req b_rw b_addr b_wdata exp_a_rdata exp_b_rdata
// a_count 2 holds the fetch request for two accesses, unused rdata columns are 0
00000000 00000000 00000001 00000001 00000000 12345678 00000000 00000000
00000000 00000000 00000001 00000001 00000004 deadbeef 00000000 00000000
00000000 00000000 00000001 00000001 00000008 00000013 00000000 00000000
00000000 00000000 00000001 00000001 0000000c a5a55a5a 00000000 00000000
00000000 00000000 00000001 00000000 00000000 00000000 00000000 12345678
00000000 00000000 00000001 00000000 00000004 00000000 00000000 deadbeef
00000001 00000000 00000000 00000000 00000000 00000000 12345678 00000000
00000001 00000008 00000000 00000000 00000000 00000000 00000013 00000000
00000000 00000000 00000001 00000001 000000fc 80000001 00000000 00000000
00000000 00000000 00000001 00000000 000000fc 00000000 00000000 80000001
00000001 000000fc 00000000 00000000 00000000 00000000 80000001 00000000
00000001 0000000c 00000001 00000001 0000000c 0f0ff0f0 0f0ff0f0 00000000
00000001 00000004 00000001 00000000 00000000 00000000 deadbeef 12345678
00000002 00000008 00000000 00000000 00000000 00000000 00000013 00000000
00000000 00000000 00000001 00000001 00000040 cafef00d 00000000 00000000
00000001 00000040 00000001 00000001 00000044 11112222 cafef00d 00000000
00000001 00000044 00000000 00000000 00000000 00000000 11112222 00000000
00000000 00000000 00000001 00000001 00000080 0000ffff 00000000 00000000
00000002 00000080 00000000 00000000 00000000 00000000 0000ffff 00000000
00000000 00000000 00000001 00000001 00000000 ffffffff 00000000 00000000
00000000 00000000 00000001 00000000 00000000 00000000 00000000 ffffffff
00000001 00000000 00000001 00000001 00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000001 00000000 0000000c 00000000 00000000 0f0ff0f0
00000000 00000000 00000001 00000001 0000007c 76543210 00000000 00000000
00000001 0000007c 00000001 00000000 0000007c 00000000 76543210 76543210

// ==== project.f ====
+incdir+logic
logic/bus_pkg.sv
logic/bus_arbiter_fsm.sv
logic/bus_request_register.sv
logic/bus_wait_timer.sv
logic/bus_ram.sv
logic/cpu_bus_subsystem.sv
testbench/bus_checker.sv
testbench/tb_cpu_bus_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the CPU bus subsystem

SIM       := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_cpu_bus_subsystem
FILE_LIST := project.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@output="$$(./$(SIM_BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_cpu_bus_subsystem.sv ====
/*
 Testbench for the CPU bus subsystem
 Replays the golden file on both ports and hands the expected
 read data to the checker
*/

`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module tb_cpu_bus_subsystem
	import bus_pkg::*;
();

	localparam int FIELDS = 8;	// Hex words per golden line
	localparam int MAX_LINES = 64;
	localparam int RESET_CYCLES = 4;

	logic clock;
	logic reset;
	logic pa_request;
	addr_t pa_address;
	logic pa_ready;
	word_t pa_rdata;
	logic pb_request;
	logic pb_rw;
	addr_t pb_address;
	word_t pb_wdata;
	logic pb_ready;
	word_t pb_rdata;

	word_t golden [FIELDS*MAX_LINES];
	int line_count;
	int cycle_limit;
	int line_no;
	int pa_count;
	int pb_count;
	word_t exp_pa_rdata;
	word_t exp_pb_rdata;
	logic line_done;
	int tests;
	int failed;
	int errors;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	cpu_bus_subsystem cpu_bus_subsystem_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_ready(pa_ready),
		.o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata),
		.o_pb_ready(pb_ready),
		.o_pb_rdata(pb_rdata)
	);

	bus_checker bus_checker_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_line(line_no),
		.i_line_done(line_done),
		.i_pa_count(pa_count),
		.i_pb_count(pb_count),
		.i_exp_pa_rdata(exp_pa_rdata),
		.i_exp_pb_rdata(exp_pb_rdata),
		.i_pa_request(pa_request),
		.i_pa_ready(pa_ready),
		.i_pa_rdata(pa_rdata),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_ready(pb_ready),
		.i_pb_rdata(pb_rdata),
		.o_tests(tests),
		.o_failed(failed),
		.o_errors(errors)
	);

	initial begin
		int base;
		int pa_left;	// A ready pulses still to come
		int pb_left;

		reset <= 1'b1;
		pa_request <= 1'b0;
		pa_address <= '0;
		pb_request <= 1'b0;
		pb_rw <= 1'b0;
		pb_address <= '0;
		pb_wdata <= '0;
		line_no <= 0;
		pa_count <= 0;
		pb_count <= 0;
		exp_pa_rdata <= '0;
		exp_pb_rdata <= '0;
		line_done <= 1'b0;

		// Unfilled entries hold their inverted index, which marks the end
		for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
			golden[i] = ~word_t'(i);
		end
		$readmemh("testbench/bus_golden.txt", golden);
		line_count = 0;
		while (line_count < MAX_LINES &&
			golden[line_count * FIELDS] != ~word_t'(line_count * FIELDS)) begin
			line_count++;
		end
		cycle_limit = line_count * (2 * `BUS_WAIT_STATES + 4) + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		for (int n = 0; n < line_count; n++) begin
			base = n * FIELDS;
			pa_left = golden[base];
			pb_left = golden[base + 2];
			line_no <= n + 1;
			pa_count <= pa_left;
			pb_count <= pb_left;
			pa_request <= (pa_left != 0);
			pa_address <= golden[base + 1];
			pb_request <= (pb_left != 0);
			pb_rw <= golden[base + 3][0];
			pb_address <= golden[base + 4];
			pb_wdata <= golden[base + 5];
			exp_pa_rdata <= golden[base + 6];
			exp_pb_rdata <= golden[base + 7];
			line_done <= 1'b0;
			while (pa_left > 0 || pb_left > 0) begin
				@(posedge clock);
				if (pa_ready && pa_left > 0) begin
					pa_left--;
					if (pa_left == 0) begin
						pa_request <= 1'b0;	// Held request ends after the last fetch
					end
				end
				if (pb_ready && pb_left > 0) begin
					pb_left--;
					if (pb_left == 0) begin
						pb_request <= 1'b0;
					end
				end
			end
			line_done <= 1'b1;
			@(posedge clock);	// Idle cycle between lines
		end
		line_done <= 1'b0;
		repeat (2) @(posedge clock);

		$display("Tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0 && failed == 0 && line_count > 0 && tests == line_count) begin
			$display("Result: PASSED");
		end
		else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog sized from the number of golden lines
	initial begin
		int cycle_count;

		cycle_count = 0;
		@(posedge clock);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_count);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/bus_checker.sv ====
/*
 Bus checker
 Watches both ports of the bus subsystem and checks read data,
 ready latency and grant order for each golden line
*/

`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module bus_checker
	import bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,
	input var int i_line,	// Golden line under test
	input wire logic i_line_done,	// Line over, arbiter idle
	input var int i_pa_count,	// Expected A accesses
	input var int i_pb_count,
	input wire word_t i_exp_pa_rdata,
	input wire word_t i_exp_pb_rdata,
	input wire logic i_pa_request,
	input wire logic i_pa_ready,
	input wire word_t i_pa_rdata,
	input wire logic i_pb_request,
	input wire logic i_pb_rw,
	input wire logic i_pb_ready,
	input wire word_t i_pb_rdata,
	output int o_tests,
	output int o_failed,
	output int o_errors
);

	// Grant cycle plus the wait states
	localparam int SLOT = `BUS_WAIT_STATES + 1;

	int cycle;
	int first_cycle;	// First cycle with a request in this line
	int pa_seen;
	int pb_seen;
	logic started;
	logic line_failed;

	task automatic report_error(input string text);
		$display("%s", text);
		line_failed = 1'b1;
		o_errors++;
	endtask

	task automatic check_latency(input string port, input int expected);
		if (started && (cycle - first_cycle != expected)) begin
			report_error($sformatf(
				"Test %0d: port %s ready came %0d cycles after the request, expected %0d",
				i_line, port, cycle - first_cycle, expected));
		end
	endtask

	task automatic finish_line();
		if (pa_seen != i_pa_count) begin
			report_error($sformatf("Test %0d: port A saw %0d ready pulses instead of %0d",
				i_line, pa_seen, i_pa_count));
		end
		if (pb_seen != i_pb_count) begin
			report_error($sformatf("Test %0d: port B saw %0d ready pulses instead of %0d",
				i_line, pb_seen, i_pb_count));
		end
		o_tests++;
		if (line_failed) begin
			o_failed++;
			$display("Test %0d failed", i_line);
		end
		else begin
			$display("Test %0d passed", i_line);
		end
		started = 1'b0;
		pa_seen = 0;
		pb_seen = 0;
		line_failed = 1'b0;
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			cycle = 0;
			first_cycle = 0;
			started = 1'b0;
			pa_seen = 0;
			pb_seen = 0;
			line_failed = 1'b0;
			o_tests = 0;
			o_failed = 0;
			o_errors = 0;
		end
		else begin
			if (!started && (i_pa_request || i_pb_request)) begin
				started = 1'b1;
				first_cycle = cycle;
			end
			if (i_pa_ready && i_pb_ready) begin
				report_error($sformatf("Test %0d: both ports got ready in the same cycle", i_line));
			end
			if (i_pa_ready) begin
				if (!i_pa_request) begin
					report_error($sformatf("Test %0d: port A got ready with its request low", i_line));
				end
				if (i_pa_rdata !== i_exp_pa_rdata) begin
					report_error($sformatf("Mismatch o_pa_rdata in test %0d: expected %h, got %h",
						i_line, i_exp_pa_rdata, i_pa_rdata));
				end
				check_latency("A", (i_pb_count + pa_seen) * SLOT + `BUS_WAIT_STATES);	// B goes first
				pa_seen++;
			end
			if (i_pb_ready) begin
				if (!i_pb_request) begin
					report_error($sformatf("Test %0d: port B got ready with its request low", i_line));
				end
				if (!i_pb_rw && (i_pb_rdata !== i_exp_pb_rdata)) begin
					report_error($sformatf("Mismatch o_pb_rdata in test %0d: expected %h, got %h",
						i_line, i_exp_pb_rdata, i_pb_rdata));
				end
				check_latency("B", pb_seen * SLOT + `BUS_WAIT_STATES);
				pb_seen++;
			end
			if (i_line_done) begin
				finish_line();
			end
			cycle++;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpu_bus_subsystem.sv ====
/*
 CPU bus subsystem
 Instruction fetch port and load/store port sharing one RAM
 through an arbiter, a request register and a wait-state timer
*/

`timescale 1ns/1ps
`default_nettype none

module cpu_bus_subsystem
	import bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,

	// Port A, instruction fetch
	input wire logic i_pa_request,
	input wire addr_t i_pa_address,
	output logic o_pa_ready,
	output word_t o_pa_rdata,

	// Port B, load/store
	input wire logic i_pb_request,
	input wire logic i_pb_rw,
	input wire addr_t i_pb_address,
	input wire word_t i_pb_wdata,
	output logic o_pb_ready,
	output word_t o_pb_rdata
);

	logic load;
	logic select_b;
	logic start;
	logic bus_ready;	// Timer done
	bus_req_t bus_request;
	word_t ram_rdata;

	bus_arbiter_fsm bus_arbiter_fsm_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pb_request(i_pb_request),
		.i_bus_ready(bus_ready),
		.o_load(load),
		.o_select_b(select_b),
		.o_start(start),
		.o_pa_ready(o_pa_ready),
		.o_pb_ready(o_pb_ready)
	);

	bus_request_register bus_request_register_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_load(load),
		.i_select_b(select_b),
		.i_pa_address(i_pa_address),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_request(bus_request)
	);

	bus_wait_timer bus_wait_timer_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(start),
		.o_done(bus_ready)
	);

	bus_ram bus_ram_inst (
		.i_clock(i_clock),
		.i_request(bus_request),
		.i_ready(bus_ready),
		.o_rdata(ram_rdata)
	);

	// Both ports see the same read word, only the ready tells them apart
	assign o_pa_rdata = ram_rdata;
	assign o_pb_rdata = ram_rdata;

endmodule

`default_nettype wire

// ==== logic/bus_ram.sv ====
/*
 Bus RAM
 Word memory behind the shared bus, combinational read from the
 latched address and write at the end of the ready cycle
*/

`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module bus_ram
	import bus_pkg::*;
(
	input wire logic i_clock,

	input wire bus_req_t i_request,	// Latched access
	input wire logic i_ready,	// Bus ready from the timer

	output word_t o_rdata
);

	localparam int WORDS = 2 ** `BUS_RAM_WORDS_LOG2;

	typedef logic [`BUS_RAM_WORDS_LOG2-1:0] word_addr_t;

	word_t mem [WORDS];
	word_addr_t word_address;

	// Drop the byte offset
	assign word_address = i_request.address[`BUS_RAM_WORDS_LOG2+1:2];

	always_ff @(posedge i_clock) begin
		if (i_ready && i_request.rw) begin
			mem[word_address] <= i_request.wdata;
		end
	end

	assign o_rdata = mem[word_address];	// Sampled by the port on ready

	// Accesses are whole words only
	a_word_aligned: assert property (
		@(posedge i_clock)
		i_ready |-> (i_request.address[1:0] == 2'b00)
	);

endmodule

`default_nettype wire

// ==== logic/bus_wait_timer.sv ====
/*
 Wait-state timer
 Counts the fixed wait states after each bus start and pulses
 bus ready in the last one
*/

`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module bus_wait_timer (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire logic i_start,
	output logic o_done
);

	localparam int COUNT_WIDTH = $clog2(`BUS_WAIT_STATES + 1);

	logic [COUNT_WIDTH-1:0] count;	// Zero when idle

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end
		else if (i_start) begin
			count <= COUNT_WIDTH'(`BUS_WAIT_STATES);
		end
		else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Last wait state, one cycle wide
	assign o_done = (count == COUNT_WIDTH'(1));

	a_start_when_idle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_start |-> (count == '0)
	);

endmodule

`default_nettype wire

// ==== logic/bus_request_register.sv ====
/*
 Bus request register
 Latches the granted port's access and keeps it steady on the bus
 until the next grant
*/

`timescale 1ns/1ps
`default_nettype none

module bus_request_register
	import bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,

	input wire logic i_load,
	input wire logic i_select_b,

	input wire addr_t i_pa_address,
	input wire logic i_pb_rw,
	input wire addr_t i_pb_address,
	input wire word_t i_pb_wdata,

	output bus_req_t o_request
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_request <= '0;
		end
		else if (i_load) begin
			if (i_select_b) begin
				o_request.rw <= i_pb_rw;
				o_request.address <= i_pb_address;
				o_request.wdata <= i_pb_wdata;
			end
			else begin
				// Fetch port is read only
				o_request.rw <= 1'b0;
				o_request.address <= i_pa_address;
				o_request.wdata <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_arbiter_fsm.sv ====
/*
 Bus arbiter
 Grants the shared bus to port A or port B, B first on a tie,
 starts the wait timer and routes bus ready to the granted port
*/

`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_fsm
	import bus_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,

	input wire logic i_pa_request,
	input wire logic i_pb_request,
	input wire logic i_bus_ready,	// Done pulse from the timer

	output logic o_load,	// Capture access into request register
	output logic o_select_b,	// Capture port B instead of A
	output logic o_start,	// Kick the wait timer
	output logic o_pa_ready,
	output logic o_pb_ready
);

	arb_state_t state;
	arb_state_t next_state;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
		end
		else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_load = 1'b0;
		o_select_b = 1'b0;
		o_start = 1'b0;

		unique case (state)
			ARB_IDLE: begin
				if (i_pb_request) begin	// B wins a tie
					o_load = 1'b1;
					o_select_b = 1'b1;
					o_start = 1'b1;
					next_state = ARB_PORT_B;
				end
				else if (i_pa_request) begin
					o_load = 1'b1;
					o_start = 1'b1;
					next_state = ARB_PORT_A;
				end
			end

			// Hold the grant until the access completes
			ARB_PORT_A, ARB_PORT_B: begin
				if (i_bus_ready) begin
					next_state = ARB_IDLE;
				end
			end

			default: next_state = ARB_IDLE;
		endcase
	end

	// Ready only reaches the port that owns the bus
	assign o_pa_ready = (state == ARB_PORT_A) && i_bus_ready;
	assign o_pb_ready = (state == ARB_PORT_B) && i_bus_ready;

	a_ready_exclusive: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!(o_pa_ready && o_pb_ready)
	);

	// A start always leaves idle for a grant state
	a_start_from_idle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_start |-> (state == ARB_IDLE) ##1 (state != ARB_IDLE)
	);

	// Timer must stay quiet while nothing is granted
	a_no_ready_in_idle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(state == ARB_IDLE) |-> !i_bus_ready
	);

endmodule

`default_nettype wire

// ==== logic/bus_pkg.sv ====
/*
 Bus package
 Word and address types, the latched bus request and the arbiter states
*/

`default_nettype none

`include "bus_consts.svh"

package bus_pkg;

	typedef logic [`BUS_WIDTH-1:0] word_t;	// Data word
	typedef logic [`BUS_WIDTH-1:0] addr_t;	// Byte address

	// One access as it sits on the bus
	typedef struct packed {
		logic rw;		// 1 = write
		addr_t address;
		word_t wdata;
	} bus_req_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,	// Instruction fetch granted
		ARB_PORT_B	// Load/store granted
	} arb_state_t;

endpackage

`default_nettype wire

// ==== logic/bus_consts.svh ====
/*
 Bus constants
 Data and address width, RAM depth and the fixed wait-state count
 shared by the memory bus subsystem
*/

`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Data and byte address width
`define BUS_WIDTH 32

// 64 words, indexed by address bits 7 to 2
`define BUS_RAM_WORDS_LOG2 6

// Cycles from bus start to bus ready, at least 1
`define BUS_WAIT_STATES 2

`endif
